// ==== source/gprPkg.sv ====
// GPR register file package with ID codes, widths and the register ID union
package gprPkg;

	// Widths
	localparam int regIdWidth = 6;       // Full register ID code
	localparam int dataWidth = 64;       // Register value
	localparam int immWidth = 33;        // Decoded immediate, bit 32 is the sign
	localparam int gprCount = 32;        // Plain storage registers
	localparam int gprIdxWidth = $clog2(gprCount);

	// Special source IDs, the two highest codes
	localparam logic [regIdWidth-1:0] idImm = 6'd62;   // Lane immediate
	localparam logic [regIdWidth-1:0] idZero = 6'd63;  // Zero, also marks an empty slot

	// The special-space flag and register index share one word with the raw code
	typedef struct packed {
		logic special;                     // Set for IDs above the register file
		logic [gprIdxWidth-1:0] index;     // Register number when not special
	} fileIdT;

	typedef union packed {
		logic [regIdWidth-1:0] raw;        // Compared against idImm and idZero
		fileIdT file;                      // Register file view
	} regIdT;

	// IDs in the special space other than idImm and idZero
	function automatic logic idReserved(regIdT id);
		logic isSpecialCode;
		isSpecialCode = (id.raw == idImm) || (id.raw == idZero);
		return id.file.special && !isSpecialCode;
	endfunction

	// Sign extension of a decoded immediate to a full register value
	function automatic logic [dataWidth-1:0] immExtend(logic [immWidth-1:0] imm);
		return {{(dataWidth - immWidth){imm[immWidth-1]}}, imm};
	endfunction

endpackage

// ==== source/gprStorage.sv ====
// GPR storage array with one write port per lane, lowest-lane priority and hold
`timescale 1ns/100ps

module gprStorage
	import gprPkg::*;
#(
	parameter int laneCount = 3
) (
	input  logic clock,
	input  logic rstN,
	input  logic hold,                                // Freezes the array
	input  regIdT regIdWb [laneCount],                // Writeback destination IDs
	input  logic [dataWidth-1:0] regValWb [laneCount], // Writeback results
	output logic [dataWidth-1:0] regValFile [gprCount] // Whole array to the read ports
);

	logic [dataWidth-1:0] gprArr [gprCount];

	// Lanes are visited from the highest down, so the lowest lane's write stands
	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int r = 0; r < gprCount; r++) begin
				gprArr[r] <= '0;
			end
		end else if (!hold) begin
			for (int l = laneCount - 1; l >= 0; l--) begin
				if (!regIdWb[l].file.special) begin  // idImm and idZero never land
					gprArr[regIdWb[l].file.index] <= regValWb[l];
				end
			end
		end
	end

	always_comb begin
		for (int r = 0; r < gprCount; r++) begin
			regValFile[r] = gprArr[r];
		end
	end

	// Writeback IDs come from the issue pipeline and must be legal codes
	for (genvar l = 0; l < laneCount; l++) begin : gWbIdChk
		assert property (@(posedge clock) disable iff (!rstN)
			!idReserved(regIdWb[l]))
			else $error("Reserved writeback ID %0d on lane %0d", regIdWb[l].raw, l);
	end

endmodule

// ==== source/gprBypass.sv ====
// GPR bypass network that finds the newest in-flight result for one read port
`timescale 1ns/100ps

module gprBypass
	import gprPkg::*;
#(
	parameter int laneCount = 3,
	parameter int stageCount = 3
) (
	input  regIdT regIdRead,                                    // Source ID being read
	input  regIdT regIdDst [stageCount][laneCount],             // Stage 0 is EX1
	input  logic [dataWidth-1:0] regValDst [stageCount][laneCount],
	output logic fwdHit,                                        // Some slot matched
	output logic [dataWidth-1:0] fwdVal                         // Newest matching value
);

	logic readIsZero;

	// idZero marks an empty slot, so it never forwards
	assign readIsZero = (regIdRead.raw == idZero);

	// Scan from the oldest stage and highest lane up to EX1 lane A.
	// Later matches overwrite earlier ones, which leaves the newest.
	always_comb begin
		fwdHit = 1'b0;
		fwdVal = '0;
		if (!readIsZero) begin
			for (int s = stageCount - 1; s >= 0; s--) begin
				for (int l = laneCount - 1; l >= 0; l--) begin
					if (regIdDst[s][l].raw == regIdRead.raw) begin
						fwdHit = 1'b1;
						fwdVal = regValDst[s][l];
					end
				end
			end
		end
	end

endmodule

// ==== source/gprReadPort.sv ====
// GPR read port that decodes a source ID into register, immediate or zero, with bypass
`timescale 1ns/100ps

module gprReadPort
	import gprPkg::*;
#(
	parameter int laneCount = 3,
	parameter int stageCount = 3
) (
	input  logic clock,                                         // Only for the ID check
	input  logic rstN,
	input  regIdT regIdRead,                                    // Source ID
	input  logic [immWidth-1:0] regValImm,                      // This lane's immediate
	input  logic [dataWidth-1:0] regValFile [gprCount],         // Storage contents
	input  regIdT regIdDst [stageCount][laneCount],
	input  logic [dataWidth-1:0] regValDst [stageCount][laneCount],
	output logic [dataWidth-1:0] regValRead                     // Value for the source
);

	logic fwdHit;
	logic [dataWidth-1:0] fwdVal;
	logic [dataWidth-1:0] immVal;

	gprBypass #(
		.laneCount (laneCount),
		.stageCount(stageCount)
	) bypass_i (
		.regIdRead(regIdRead),
		.regIdDst (regIdDst),
		.regValDst(regValDst),
		.fwdHit   (fwdHit),
		.fwdVal   (fwdVal)
	);

	assign immVal = immExtend(regValImm);  // Sign from bit 32

	// File view picks the register, raw view tells the immediate from zero
	always_comb begin
		if (!regIdRead.file.special) begin
			if (fwdHit) begin
				regValRead = fwdVal;         // In-flight result is newer than storage
			end else begin
				regValRead = regValFile[regIdRead.file.index];
			end
		end else if (regIdRead.raw == idImm) begin
			regValRead = immVal;
		end else begin
			regValRead = '0;               // idZero
		end
	end

	// Decode must never hand this port a reserved code
	assert property (@(posedge clock) disable iff (!rstN)
		!idReserved(regIdRead))
		else $error("Reserved source ID %0d", regIdRead.raw);

endmodule

// ==== source/gprRegFile.sv ====
// GPR register file top, 32x64 storage with two bypassed read ports per issue lane
`timescale 1ns/100ps

module gprRegFile
	import gprPkg::*;
#(
	parameter int laneCount = 3,   // Issue lanes, 1 to 4
	parameter int stageCount = 3   // Bypass stages, 1 to 4, last one is writeback
) (
	input  logic clock,
	input  logic rstN,
	input  logic hold,                                          // Suppresses storage writes
	input  regIdT regIdSrc [2*laneCount],                       // Ports 2l and 2l+1 for lane l
	output logic [dataWidth-1:0] regValSrc [2*laneCount],
	input  logic [immWidth-1:0] regValImm [laneCount],          // Decoded lane immediates
	input  regIdT regIdDst [stageCount][laneCount],             // Stage 0 is EX1
	input  logic [dataWidth-1:0] regValDst [stageCount][laneCount]
);

	regIdT regIdWb [laneCount];
	logic [dataWidth-1:0] regValWb [laneCount];
	logic [dataWidth-1:0] regValFile [gprCount];

	// Writeback row of the destination arrays
	assign regIdWb = regIdDst[stageCount-1];
	assign regValWb = regValDst[stageCount-1];

	gprStorage #(
		.laneCount(laneCount)
	) storage_i (
		.clock     (clock),
		.rstN      (rstN),
		.hold      (hold),
		.regIdWb   (regIdWb),
		.regValWb  (regValWb),
		.regValFile(regValFile)
	);

	// Both ports of a lane share that lane's immediate
	for (genvar p = 0; p < 2 * laneCount; p++) begin : gReadPort
		gprReadPort #(
			.laneCount (laneCount),
			.stageCount(stageCount)
		) readPort_i (
			.clock     (clock),
			.rstN      (rstN),
			.regIdRead (regIdSrc[p]),
			.regValImm (regValImm[p/2]),
			.regValFile(regValFile),
			.regIdDst  (regIdDst),
			.regValDst (regValDst),
			.regValRead(regValSrc[p])
		);
	end

endmodule

// ==== tb/gprRefModel.svh ====
// GPR reference model with a shadow register array and the expected value of a read
`ifndef GPR_REF_MODEL_SVH
`define GPR_REF_MODEL_SVH

logic [dataWidth-1:0] shadowGpr [gprCount];  // Mirrors the storage array

// Storage rule at one clock edge, lowest lane last so it stands
task automatic updateShadow();
	logic [regIdWidth-1:0] id;
	if (!rstN) begin
		for (int r = 0; r < gprCount; r++) begin
			shadowGpr[r] = '0;
		end
	end else if (!hold) begin
		for (int l = laneCount - 1; l >= 0; l--) begin
			id = regIdDst[stageCount-1][l].raw;
			if (int'(id) < gprCount) begin  // idImm and idZero are not registers
				shadowGpr[id[gprIdxWidth-1:0]] = regValDst[stageCount-1][l];
			end
		end
	end
endtask

// Expected value of one read port
function automatic logic [dataWidth-1:0] expectRead(int port);
	logic [regIdWidth-1:0] id;
	logic signed [immWidth-1:0] immSigned;
	logic [dataWidth-1:0] value;
	bit found;
	id = regIdSrc[port].raw;
	immSigned = regValImm[port / 2];  // Both ports of a lane share it
	found = 1'b0;
	if (id == idZero) begin
		value = '0;
	end else if (id == idImm) begin
		value = dataWidth'(immSigned);  // Signed cast extends bit 32
	end else begin
		value = shadowGpr[id[gprIdxWidth-1:0]];
		// EX1 is searched first, and lane A first within a stage
		for (int s = 0; s < stageCount; s++) begin
			for (int l = 0; l < laneCount; l++) begin
				if (!found && regIdDst[s][l].raw == id) begin
					found = 1'b1;
					value = regValDst[s][l];
				end
			end
		end
	end
	return value;
endfunction

`endif

// ==== tb/gprTb.sv ====
// Testbench for the GPR register file, random stimulus checked against a reference model
`timescale 1ns/100ps

module gprTb
	import gprPkg::*;
();

	localparam int laneCount = 3;
	localparam int stageCount = 3;
	localparam int portCount = 2 * laneCount;
	localparam int allStages = (1 << stageCount) - 1;
	localparam int wbStage = 1 << (stageCount - 1);
	localparam int resetCycles = 3;
	localparam int resetLen = gprCount;  // Each port steps through every register
	localparam int writeLen = 200;
	localparam int bypassLen = 300;
	localparam int immLen = 100;
	localparam int holdLen = 100;
	localparam int randomLen = 2000;
	localparam int testLen = resetLen + writeLen + bypassLen + immLen + holdLen + randomLen;
	localparam int timeoutLimit = 2 * testLen + resetCycles;

	logic clock = 1'b0;
	logic rstN;
	logic hold;
	regIdT regIdSrc [portCount];
	logic [dataWidth-1:0] regValSrc [portCount];
	logic [immWidth-1:0] regValImm [laneCount];
	regIdT regIdDst [stageCount][laneCount];
	logic [dataWidth-1:0] regValDst [stageCount][laneCount];

	integer seed;
	int cycleCount = 0;
	int errorCount = 0;
	logic [dataWidth-1:0] expected;

	`include "gprRefModel.svh"

	gprRegFile dut_i (
		.clock    (clock),
		.rstN     (rstN),
		.hold     (hold),
		.regIdSrc (regIdSrc),
		.regValSrc(regValSrc),
		.regValImm(regValImm),
		.regIdDst (regIdDst),
		.regValDst(regValDst)
	);

	always #2 clock = ~clock;  // 4 ns period

	always @(posedge clock) begin
		updateShadow();  // Sees the inputs of this edge, before the new drive lands
	end

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit) begin
			$display("The run timed out after %0d cycles without finishing", cycleCount);
			$display("Simulation failed");
			$fatal(1, "Timeout");
		end
	end

	// Inputs change on the rising edge, so outputs are settled at the falling edge
	always @(negedge clock) begin
		if (rstN) begin
			for (int p = 0; p < portCount; p++) begin
				expected = expectRead(p);
				assert (regValSrc[p] === expected) else begin
					errorCount++;
					$display("ERROR time=%0t regValSrc[%0d] actual=%h expected=%h",
						$time, p, regValSrc[p], expected);
					$display("Simulation failed");
					$fatal(1, "Read value mismatch");
				end
			end
		end
	end

	function automatic int randBelow(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Register 0 to regSpan-1, idImm or idZero
	function automatic logic [regIdWidth-1:0] randId(int regSpan);
		int k;
		k = randBelow(regSpan + 2);
		if (k < regSpan) begin
			return regIdWidth'(k);
		end else if (k == regSpan) begin
			return idImm;
		end
		return idZero;
	endfunction

	function automatic logic [dataWidth-1:0] randWord();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic initInputs();
		rstN = 1'b0;
		hold = 1'b0;
		for (int p = 0; p < portCount; p++) begin
			regIdSrc[p].raw = idZero;
		end
		for (int l = 0; l < laneCount; l++) begin
			regValImm[l] = '0;
		end
		for (int s = 0; s < stageCount; s++) begin
			for (int l = 0; l < laneCount; l++) begin
				regIdDst[s][l].raw = idZero;
				regValDst[s][l] = '0;
			end
		end
	endtask

	// Walks every register on every port with all slots empty
	task automatic readAfterReset(int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(posedge clock);
			hold <= 1'b0;
			for (int p = 0; p < portCount; p++) begin
				regIdSrc[p].raw <= regIdWidth'((c + p) % gprCount);
			end
			for (int s = 0; s < stageCount; s++) begin
				for (int l = 0; l < laneCount; l++) begin
					regIdDst[s][l].raw <= idZero;
					regValDst[s][l] <= randWord();  // Empty slots still carry data
				end
			end
		end
	endtask

	// One cycle of random inputs, stageMask picks the stages that carry results
	task automatic driveCycle(int regSpan, int stageMask, int holdPercent);
		logic [regIdWidth-1:0] wbLead;
		bit dupWb;
		wbLead = randId(regSpan);
		dupWb = (randBelow(4) == 0);  // All writeback lanes hit one register
		@(posedge clock);
		hold <= (randBelow(100) < holdPercent);
		for (int p = 0; p < portCount; p++) begin
			regIdSrc[p].raw <= randId(regSpan);
		end
		for (int l = 0; l < laneCount; l++) begin
			regValImm[l] <= immWidth'({$random(seed), $random(seed)});
		end
		for (int s = 0; s < stageCount; s++) begin
			for (int l = 0; l < laneCount; l++) begin
				regValDst[s][l] <= randWord();
				if (!stageMask[s]) begin
					regIdDst[s][l].raw <= idZero;
				end else if (s == stageCount - 1 && dupWb) begin
					regIdDst[s][l].raw <= wbLead;
				end else begin
					regIdDst[s][l].raw <= randId(regSpan);
				end
			end
		end
	endtask

	initial begin
		seed = 82984;
		initInputs();
		repeat (resetCycles) @(posedge clock);
		rstN <= 1'b1;
		readAfterReset(resetLen);
		repeat (writeLen) driveCycle(gprCount, wbStage, 0);      // Writeback only
		repeat (bypassLen) driveCycle(4, allStages, 0);          // Dense overlaps
		repeat (immLen) driveCycle(0, allStages, 0);             // Only idImm and idZero
		repeat (holdLen / 2) driveCycle(8, allStages, 100);
		repeat (holdLen / 2) driveCycle(8, allStages, 0);        // Writes resume
		for (int c = 0; c < randomLen; c++) begin
			driveCycle((c % 2 == 1) ? gprCount : 6, allStages, 10);
		end
		@(posedge clock);  // Last falling-edge check is done by now
		if (errorCount == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1, "Checks failed");
		end
	end

endmodule

// ==== flist.f ====
+incdir+tb
source/gprPkg.sv
source/gprStorage.sv
source/gprBypass.sv
source/gprReadPort.sv
source/gprRegFile.sv
tb/gprTb.sv

// ==== Makefile ====
# Verilator build and run for the GPR register file testbench

VERILATOR ?= verilator
TOP       ?= gprTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --assert --timing -j $(JOBS)

SOURCES := $(wildcard source/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG JOBS VFLAGS"

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
		echo "FAIL: no result in $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
